// File: divsqrt_multi.f
+incdir+design
design/divsqrt_pkg.sv
design/pipe_stages.sv
design/iter_divider.sv
design/iter_sqrt.sv
design/divsqrt_sequencer.sv
design/divsqrt_multi.sv
bench/tb_divsqrt_multi.sv

// File: run.sh
#!/bin/sh
# Compile and run the divsqrt_multi regression with Verilator
# The log is searched for the fail message to decide the outcome

rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_divsqrt_multi \
  -f divsqrt_multi.f -o sim_divsqrt_multi \
  && ./obj_dir/sim_divsqrt_multi > sim.log \
  ; cat sim.log \
  && test -s sim.log \
  && ! grep -q "Regression failed" sim.log \
  && echo "Simulation finished without failures" \
  || { echo "Simulation reported failure"; exit 1; }

// File: bench/tb_divsqrt_multi.sv
`include "divsqrt_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_divsqrt_multi;

  // Request mix per phase
  localparam int ModeDiv   = 0;
  localparam int ModeSqrt  = 1;
  localparam int ModeMixed = 2;

  // Three random phases plus the flush sequence
  localparam int NumOps        = 200 + 100 + 200 + 3;
  localparam int TimeoutCycles =
    NumOps * (`DS_WIDTH + `DS_INP_REGS + `DS_OUT_REGS + 16) + 100;

  // DUT ports
  logic              clk;
  logic              rst_n_i;
  logic              flush_i;
  logic              in_valid_i;
  logic              in_ready_o;
  divsqrt_pkg::req_t req_i;
  logic              out_valid_o;
  logic              out_ready_i;
  divsqrt_pkg::rsp_t rsp_o;
  logic              busy_o;

  // Stimulus state
  logic [31:0]       lfsr_q;
  divsqrt_pkg::tag_t next_tag;
  divsqrt_pkg::req_t pend_req;
  logic              pend;
  int                gen_left;
  int                mode;
  string             test_name;

  // Scoreboard
  divsqrt_pkg::rsp_t exp_q[$];
  divsqrt_pkg::rsp_t hold_rsp;
  logic              hold_chk;
  int                err_cnt;
  int                done_cnt;
  int                cycle_cnt;

  divsqrt_multi u_divsqrt_multi (
    .clk_i       (clk),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .req_i       (req_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rsp_o       (rsp_o),
    .busy_o      (busy_o)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Cycle limit for the whole run
  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Regression failed");
    $finish;
  end

  // --------------------
  // Random source
  // --------------------
  // Fibonacci LFSR x^32+x^22+x^2+x+1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic divsqrt_pkg::req_t make_req();
    divsqrt_pkg::req_t req;
    req.operand_a = divsqrt_pkg::operand_t'(rand_bits(`DS_WIDTH));
    req.operand_b = divsqrt_pkg::operand_t'(rand_bits(`DS_WIDTH));
    req.tag       = next_tag;
    if (mode == ModeDiv) begin
      req.op = divsqrt_pkg::OP_DIV;
      // Keep the divisor nonzero here
      if (req.operand_b == '0) begin
        req.operand_b = divsqrt_pkg::operand_t'(1);
      end
    end else if (mode == ModeSqrt) begin
      req.op = divsqrt_pkg::OP_SQRT;
    end else begin
      req.op = (rand_bits(1) == 32'd1) ? divsqrt_pkg::OP_SQRT : divsqrt_pkg::OP_DIV;
      // Zero divisor one time in eight
      if (rand_bits(3) == 32'd0) begin
        req.operand_b = '0;
      end
    end
    return req;
  endfunction

  // --------------------
  // Reference model
  // --------------------
  function automatic int unsigned floor_sqrt(input int unsigned a);
    int unsigned r;
    r = 0;
    while ((r + 1) * (r + 1) <= a) begin
      r++;
    end
    return r;
  endfunction

  function automatic divsqrt_pkg::rsp_t expect_rsp(input divsqrt_pkg::req_t req);
    divsqrt_pkg::rsp_t rsp;
    int unsigned       a;
    int unsigned       b;
    int unsigned       r;
    a       = req.operand_a;
    b       = req.operand_b;
    rsp.tag = req.tag;
    if (req.op == divsqrt_pkg::OP_SQRT) begin
      // operand_b plays no part
      r                   = floor_sqrt(a);
      rsp.result          = divsqrt_pkg::operand_t'(r);
      rsp.status.div_zero = 1'b0;
      rsp.status.inexact  = (a != r * r);
    end else if (b == 0) begin
      rsp.result          = '1;
      rsp.status.div_zero = 1'b1;
      rsp.status.inexact  = (a != 0);
    end else begin
      rsp.result          = divsqrt_pkg::operand_t'(a / b);
      rsp.status.div_zero = 1'b0;
      rsp.status.inexact  = ((a % b) != 0);
    end
    return rsp;
  endfunction

  task automatic check_rsp();
    divsqrt_pkg::rsp_t exp_rsp;
    if (exp_q.size() == 0) begin
      err_cnt++;
      $display("%s: a response with tag %0d came out with no request outstanding",
               test_name, rsp_o.tag);
    end else begin
      exp_rsp = exp_q.pop_front();
      done_cnt++;
      if (rsp_o.tag !== exp_rsp.tag) begin
        err_cnt++;
        $display("ERROR %s: tag expected %h, actual %h", test_name, exp_rsp.tag, rsp_o.tag);
      end
      if (rsp_o.result !== exp_rsp.result) begin
        err_cnt++;
        $display("ERROR %s: result expected %h, actual %h (tag %0d)",
                 test_name, exp_rsp.result, rsp_o.result, exp_rsp.tag);
      end
      if (rsp_o.status !== exp_rsp.status) begin
        err_cnt++;
        $display("ERROR %s: status expected %b, actual %b (tag %0d)",
                 test_name, exp_rsp.status, rsp_o.status, exp_rsp.tag);
      end
    end
  endtask

  // --------------------
  // Cycle driver
  // --------------------
  // Drive on the falling edge and judge handshakes at the rising edge
  task automatic run_cycle();
    @(negedge clk);
    if (!pend && gen_left > 0 && rand_bits(2) != 32'd0) begin
      pend_req = make_req();
      pend     = 1'b1;
      gen_left--;
    end
    in_valid_i  = pend;
    req_i       = pend_req;
    // Back-pressure one cycle in four
    out_ready_i = (rand_bits(2) != 32'd0);
    @(posedge clk);
    // Stalled response must not move
    if (hold_chk && out_valid_o && rsp_o !== hold_rsp) begin
      err_cnt++;
      $display("ERROR %s: stalled rsp expected %h, actual %h", test_name, hold_rsp, rsp_o);
    end
    hold_chk = out_valid_o & ~out_ready_i;
    hold_rsp = rsp_o;
    if (in_valid_i && in_ready_o) begin
      exp_q.push_back(expect_rsp(pend_req));
      pend     = 1'b0;
      next_tag = next_tag + 1'b1;
    end
    if (out_valid_o && out_ready_i) begin
      check_rsp();
    end
  endtask

  task automatic run_phase(input string name, input int phase_mode, input int num_ops);
    test_name = name;
    mode      = phase_mode;
    gen_left  = num_ops;
    while (gen_left > 0 || pend) begin
      run_cycle();
    end
    // Drain everything still in flight
    while (exp_q.size() > 0) begin
      run_cycle();
    end
  endtask

  task automatic send_one();
    pend_req = make_req();
    pend     = 1'b1;
    while (pend) begin
      run_cycle();
    end
  endtask

  task automatic flush_check();
    test_name = "flush";
    mode      = ModeDiv;
    gen_left  = 0;
    // One request reaches the divider and one waits in the input stage
    send_one();
    send_one();
    run_cycle();
    run_cycle();
    @(negedge clk);
    // Work is in flight right before the flush
    if (busy_o !== 1'b1) begin
      err_cnt++;
      $display("ERROR flush: busy_o before flush expected 1, actual %b", busy_o);
    end
    flush_i     = 1'b1;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    @(posedge clk);
    @(negedge clk);
    flush_i = 1'b0;
    exp_q.delete();
    hold_chk = 1'b0;
    if (busy_o !== 1'b0) begin
      err_cnt++;
      $display("ERROR flush: busy_o expected 0, actual %b", busy_o);
    end
    // Any flushed result showing up now hits an empty queue
    repeat (2 * `DS_WIDTH) run_cycle();
    test_name = "after_flush";
    send_one();
    while (exp_q.size() > 0) begin
      run_cycle();
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin : main
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    req_i       = '0;
    lfsr_q      = 32'd70325;
    next_tag    = '0;
    pend_req    = '0;
    pend        = 1'b0;
    gen_left    = 0;
    mode        = ModeDiv;
    hold_rsp    = '0;
    hold_chk    = 1'b0;
    err_cnt     = 0;
    done_cnt    = 0;
    test_name   = "reset";

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    if (out_valid_o !== 1'b0) begin
      err_cnt++;
      $display("ERROR reset: out_valid_o expected 0, actual %b", out_valid_o);
    end
    if (busy_o !== 1'b0) begin
      err_cnt++;
      $display("ERROR reset: busy_o expected 0, actual %b", busy_o);
    end
    if (in_ready_o !== 1'b1) begin
      err_cnt++;
      $display("ERROR reset: in_ready_o expected 1, actual %b", in_ready_o);
    end

    run_phase("div", ModeDiv, 200);
    run_phase("sqrt", ModeSqrt, 100);
    run_phase("mixed", ModeMixed, 200);
    flush_check();

    $display("Checked %0d responses in %0d cycles, %0d errors", done_cnt, cycle_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/divsqrt_multi.sv
`include "divsqrt_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module divsqrt_multi (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              flush_i,
  input  wire logic              in_valid_i,
  output logic                   in_ready_o,
  input  wire divsqrt_pkg::req_t req_i,
  output logic                   out_valid_o,
  input  wire logic              out_ready_i,
  output divsqrt_pkg::rsp_t      rsp_o,
  output logic                   busy_o
);

  localparam int unsigned ReqWidth = $bits(divsqrt_pkg::req_t);
  localparam int unsigned RspWidth = $bits(divsqrt_pkg::rsp_t);

  // Input stages to sequencer
  logic [ReqWidth-1:0] inp_data;
  divsqrt_pkg::req_t   seq_req;
  logic                seq_req_valid;
  logic                seq_req_ready;

  // Sequencer to output stages
  divsqrt_pkg::rsp_t   seq_rsp;
  logic                seq_rsp_valid;
  logic                seq_rsp_ready;
  logic [RspWidth-1:0] out_data;

  // Work in flight per block
  logic inp_busy;
  logic seq_busy;
  logic out_busy;

  // --------------------
  // Input pipeline
  // --------------------
  pipe_stages #(
    .NumStages (`DS_INP_REGS),
    .DataWidth (ReqWidth)
  ) u_inp_stages (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (req_i),
    .valid_o (seq_req_valid),
    .ready_i (seq_req_ready),
    .data_o  (inp_data),
    .busy_o  (inp_busy)
  );

  assign seq_req = divsqrt_pkg::req_t'(inp_data);

  divsqrt_sequencer u_sequencer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .req_valid_i (seq_req_valid),
    .req_ready_o (seq_req_ready),
    .req_i       (seq_req),
    .rsp_valid_o (seq_rsp_valid),
    .rsp_ready_i (seq_rsp_ready),
    .rsp_o       (seq_rsp),
    .busy_o      (seq_busy)
  );

  // --------------------
  // Output pipeline
  // --------------------
  pipe_stages #(
    .NumStages (`DS_OUT_REGS),
    .DataWidth (RspWidth)
  ) u_out_stages (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (seq_rsp_valid),
    .ready_o (seq_rsp_ready),
    .data_i  (seq_rsp),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_data),
    .busy_o  (out_busy)
  );

  assign rsp_o  = divsqrt_pkg::rsp_t'(out_data);
  assign busy_o = inp_busy | seq_busy | out_busy;

endmodule

`default_nettype wire

// File: design/divsqrt_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module divsqrt_sequencer (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              flush_i,
  input  wire logic              req_valid_i,
  output logic                   req_ready_o,
  input  wire divsqrt_pkg::req_t req_i,
  output logic                   rsp_valid_o,
  input  wire logic              rsp_ready_i,
  output divsqrt_pkg::rsp_t      rsp_o,
  output logic                   busy_o
);

  // FSM
  divsqrt_pkg::seq_state_e state_q;
  divsqrt_pkg::seq_state_e state_d;

  // Handshake and start
  logic in_ready;
  logic out_valid;
  logic op_start;
  logic start_div;
  logic start_sqrt;
  logic unit_done;

  // Operation context, captured at start
  divsqrt_pkg::op_e  op_q;
  divsqrt_pkg::tag_t tag_q;

  // Engine results
  divsqrt_pkg::operand_t div_quot;
  logic                  div_zero;
  logic                  div_rem_nz;
  logic                  div_done;
  divsqrt_pkg::operand_t sqrt_root;
  logic                  sqrt_rest_nz;
  logic                  sqrt_done;

  // No new work starts during a flush
  assign op_start   = req_valid_i & in_ready & ~flush_i;
  assign start_div  = op_start & (req_i.op == divsqrt_pkg::OP_DIV);
  assign start_sqrt = op_start & (req_i.op == divsqrt_pkg::OP_SQRT);

  // Done of the engine that is running
  assign unit_done = (op_q == divsqrt_pkg::OP_DIV) ? div_done : sqrt_done;

  // --------------------
  // Control FSM
  // --------------------
  always_comb begin
    in_ready  = 1'b0;
    out_valid = 1'b0;
    state_d   = state_q;

    unique case (state_q)
      divsqrt_pkg::IDLE: begin
        // Free for new work
        in_ready = 1'b1;
        if (req_valid_i) begin
          state_d = divsqrt_pkg::BUSY;
        end
      end
      divsqrt_pkg::BUSY: begin
        if (unit_done) begin
          out_valid = 1'b1;
          if (rsp_ready_i) begin
            // Result taken, next request may start right away
            in_ready = 1'b1;
            state_d  = req_valid_i ? divsqrt_pkg::BUSY : divsqrt_pkg::IDLE;
          end else begin
            state_d = divsqrt_pkg::HOLD;
          end
        end
      end
      divsqrt_pkg::HOLD: begin
        // Engine registers keep the result stable
        out_valid = 1'b1;
        if (rsp_ready_i) begin
          in_ready = 1'b1;
          state_d  = req_valid_i ? divsqrt_pkg::BUSY : divsqrt_pkg::IDLE;
        end
      end
      default: state_d = divsqrt_pkg::IDLE;
    endcase

    // Flush wins over everything
    if (flush_i) begin
      out_valid = 1'b0;
      state_d   = divsqrt_pkg::IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= divsqrt_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Context registers
  always_ff @(posedge clk_i) begin
    if (op_start) begin
      op_q  <= req_i.op;
      tag_q <= req_i.tag;
    end
  end

  // --------------------
  // Engines
  // --------------------
  iter_divider u_iter_divider (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .kill_i     (flush_i),
    .start_i    (start_div),
    .dividend_i (req_i.operand_a),
    .divisor_i  (req_i.operand_b),
    .quotient_o (div_quot),
    .div_zero_o (div_zero),
    .rem_nz_o   (div_rem_nz),
    .done_o     (div_done)
  );

  // Sqrt only uses operand_a
  iter_sqrt u_iter_sqrt (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .kill_i     (flush_i),
    .start_i    (start_sqrt),
    .radicand_i (req_i.operand_a),
    .root_o     (sqrt_root),
    .rest_nz_o  (sqrt_rest_nz),
    .done_o     (sqrt_done)
  );

  // Result select by the captured op
  always_comb begin
    if (op_q == divsqrt_pkg::OP_DIV) begin
      rsp_o.result          = div_quot;
      rsp_o.status.div_zero = div_zero;
      rsp_o.status.inexact  = div_rem_nz;
    end else begin
      rsp_o.result          = sqrt_root;
      rsp_o.status.div_zero = 1'b0;
      rsp_o.status.inexact  = sqrt_rest_nz;
    end
    rsp_o.tag = tag_q;
  end

  assign req_ready_o = in_ready;
  assign rsp_valid_o = out_valid;
  // Operation in the engines or result waiting
  assign busy_o      = (state_q != divsqrt_pkg::IDLE);

endmodule

`default_nettype wire

// File: design/iter_sqrt.sv
`include "divsqrt_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module iter_sqrt (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  kill_i,
  input  wire logic                  start_i,
  input  wire divsqrt_pkg::operand_t radicand_i,
  output divsqrt_pkg::operand_t      root_o,
  output logic                       rest_nz_o,
  output logic                       done_o
);

  localparam int unsigned Width     = `DS_WIDTH;
  localparam int unsigned HalfWidth = Width / 2;
  // Partial remainder never exceeds twice the root
  localparam int unsigned RemWidth  = HalfWidth + 2;
  localparam int unsigned CntWidth  = $clog2(HalfWidth);

  // Iteration control
  logic                run_q;
  logic                done_q;
  logic [CntWidth-1:0] cnt_q;
  logic                step_en;

  // Datapath registers
  divsqrt_pkg::operand_t rad_q;  // radicand, consumed two bits per step
  logic [HalfWidth-1:0]  root_q;
  logic [RemWidth-1:0]   rem_q;

  // One digit step
  divsqrt_pkg::operand_t rad_cur;
  logic [HalfWidth-1:0]  root_cur;
  logic [RemWidth-1:0]   rem_cur;
  logic [RemWidth+1:0]   shifted;
  logic [RemWidth+1:0]   trial;
  logic                  r_bit;
  logic [RemWidth-1:0]   rem_nxt;
  logic [HalfWidth-1:0]  root_nxt;

  assign step_en = start_i | run_q;

  always_comb begin
    if (start_i) begin
      rad_cur  = radicand_i;
      root_cur = '0;
      rem_cur  = '0;
    end else begin
      rad_cur  = rad_q;
      root_cur = root_q;
      rem_cur  = rem_q;
    end
    // Append next radicand pair to the remainder
    shifted = {rem_cur, rad_cur[Width-1 -: 2]};
    // Trial subtrahend is 4*root + 1
    trial   = (RemWidth + 2)'({root_cur, 2'b01});
    r_bit   = (shifted >= trial);
    // Truncation is safe, remainder stays below 2*root + 1
    rem_nxt  = r_bit ? RemWidth'(shifted - trial) : RemWidth'(shifted);
    root_nxt = {root_cur[HalfWidth-2:0], r_bit};
  end

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (kill_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        run_q <= 1'b1;
        cnt_q <= CntWidth'(HalfWidth - 1);
      end else if (run_q) begin
        cnt_q <= cnt_q - 1'b1;
        // Final digit lands on this edge
        if (cnt_q == CntWidth'(1)) begin
          run_q  <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge clk_i) begin
    if (step_en) begin
      rad_q  <= {rad_cur[Width-3:0], 2'b00};
      root_q <= root_nxt;
      rem_q  <= rem_nxt;
    end
  end

  // Root occupies the lower half
  assign root_o    = {{(Width - HalfWidth){1'b0}}, root_q};
  assign rest_nz_o = |rem_q;
  assign done_o    = done_q;

endmodule

`default_nettype wire

// File: design/iter_divider.sv
`include "divsqrt_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module iter_divider (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  kill_i,
  input  wire logic                  start_i,
  input  wire divsqrt_pkg::operand_t dividend_i,
  input  wire divsqrt_pkg::operand_t divisor_i,
  output divsqrt_pkg::operand_t      quotient_o,
  output logic                       div_zero_o,
  output logic                       rem_nz_o,
  output logic                       done_o
);

  localparam int unsigned Width    = `DS_WIDTH;
  localparam int unsigned CntWidth = $clog2(Width);

  // Iteration control
  logic                run_q;
  logic                done_q;
  logic [CntWidth-1:0] cnt_q;
  logic                step_en;

  // Datapath registers
  divsqrt_pkg::operand_t rem_q;
  divsqrt_pkg::operand_t quo_q;  // dividend shifts out, quotient shifts in
  divsqrt_pkg::operand_t dsr_q;
  logic                  div_zero_q;

  // One restoring step
  divsqrt_pkg::operand_t rem_cur;
  divsqrt_pkg::operand_t quo_cur;
  divsqrt_pkg::operand_t dsr_cur;
  logic [Width:0]        trial;
  divsqrt_pkg::operand_t diff;
  logic                  q_bit;
  divsqrt_pkg::operand_t rem_nxt;
  divsqrt_pkg::operand_t quo_nxt;

  // First step already runs in the start cycle
  assign step_en = start_i | run_q;

  always_comb begin
    // Start takes fresh operands, otherwise continue from registers
    if (start_i) begin
      rem_cur = '0;
      quo_cur = dividend_i;
      dsr_cur = divisor_i;
    end else begin
      rem_cur = rem_q;
      quo_cur = quo_q;
      dsr_cur = dsr_q;
    end
    // Bring down next dividend bit
    trial = {rem_cur, quo_cur[Width-1]};
    // Low bits suffice, the true difference is below the divisor
    diff  = trial[Width-1:0] - dsr_cur;
    // Zero divisor always subtracts, so all ones and rem = dividend
    q_bit   = (trial >= {1'b0, dsr_cur});
    rem_nxt = q_bit ? diff : trial[Width-1:0];
    quo_nxt = {quo_cur[Width-2:0], q_bit};
  end

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (kill_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      // Done is a one cycle pulse
      done_q <= 1'b0;
      if (start_i) begin
        run_q <= 1'b1;
        cnt_q <= CntWidth'(Width - 1);
      end else if (run_q) begin
        cnt_q <= cnt_q - 1'b1;
        // Last step happens on this edge
        if (cnt_q == CntWidth'(1)) begin
          run_q  <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Datapath, holds its value once the count runs out
  always_ff @(posedge clk_i) begin
    if (step_en) begin
      rem_q <= rem_nxt;
      quo_q <= quo_nxt;
    end
    if (start_i) begin
      dsr_q      <= divisor_i;
      div_zero_q <= (divisor_i == '0);
    end
  end

  assign quotient_o = quo_q;
  assign div_zero_o = div_zero_q;
  assign rem_nz_o   = |rem_q;
  assign done_o     = done_q;

endmodule

`default_nettype wire

// File: design/pipe_stages.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_stages #(
  parameter int unsigned NumStages = 1,
  parameter int unsigned DataWidth = 8
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 flush_i,
  input  wire logic                 valid_i,
  output logic                      ready_o,
  input  wire logic [DataWidth-1:0] data_i,
  output logic                      valid_o,
  input  wire logic                 ready_i,
  output logic [DataWidth-1:0]      data_o,
  output logic                      busy_o
);

  // Index i holds the item after i register stages
  logic [DataWidth-1:0] stage_data  [NumStages+1];
  logic                 stage_valid [NumStages+1];
  // Ready runs backwards, purely combinational
  logic                 stage_ready [NumStages+1];

  // Chain entry from upstream
  assign stage_data[0]  = data_i;
  assign stage_valid[0] = valid_i;
  assign ready_o        = stage_ready[0];

  for (genvar i = 0; i < NumStages; i++) begin : gen_stage
    logic stage_en;

    // Advance when the next stage moves on or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    // Load payload only for a real item
    assign stage_en = stage_ready[i] & stage_valid[i];

    // Valid flag, flush drops whatever sits here
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    // Payload register
    always_ff @(posedge clk_i) begin
      if (stage_en) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  // Chain exit towards downstream
  assign stage_ready[NumStages] = ready_i;
  assign valid_o                = stage_valid[NumStages];
  assign data_o                 = stage_data[NumStages];

  // Any stage holding an item
  always_comb begin
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NumStages; i++) begin
      busy_o = busy_o | stage_valid[i];
    end
  end

endmodule

`default_nettype wire

// File: design/divsqrt_pkg.sv
`include "divsqrt_defines.svh"
`default_nettype none

package divsqrt_pkg;

  // --------------------
  // Basic vectors
  // --------------------
  // Operand or result value
  typedef logic [`DS_WIDTH-1:0] operand_t;
  // Requester tag, returned unchanged
  typedef logic [`DS_TAG_WIDTH-1:0] tag_t;

  // Operation select
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } op_e;

  // Result flags
  typedef struct packed {
    logic div_zero;  // divisor was zero
    logic inexact;   // remainder left over
  } status_t;

  // --------------------
  // Transfer bundles
  // --------------------
  // Request as seen at the input port
  typedef struct packed {
    operand_t operand_a;
    operand_t operand_b;
    op_e      op;
    tag_t     tag;
  } req_t;

  // Response as seen at the output port
  typedef struct packed {
    operand_t result;
    status_t  status;
    tag_t     tag;
  } rsp_t;

  // Sequencer FSM states
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    HOLD
  } seq_state_e;

endpackage

`default_nettype wire

// File: design/divsqrt_defines.svh
`ifndef DIVSQRT_DEFINES_SVH
`define DIVSQRT_DEFINES_SVH

// Operand and result width in bits
`define DS_WIDTH 16

// Width of the tag that travels with each request
`define DS_TAG_WIDTH 4

// Register stages in front of the sequencer
`define DS_INP_REGS 1

// Register stages behind the sequencer
`define DS_OUT_REGS 1

`endif
